// ==== design/rv_alu.sv ====
//--------------------------------------------------------------------------
// Integer ALU
// 32-bit arithmetic, logic, shift and compare with a zero flag
//--------------------------------------------------------------------------
module rv_alu
  import rv_isa_pkg::*;
(
  input  alu_fn_t     alu_fn,
  input  logic [31:0] operand_a,
  input  logic [31:0] operand_b,
  output logic [31:0] result,
  output logic        zero
);

  logic [4:0] shamt;

  // Shift amount, low five bits only
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_fn)
      ALU_ADD: begin
        result = operand_a + operand_b;
      end
      ALU_SUB: begin
        result = operand_a - operand_b;
      end
      ALU_SLL: begin
        result = operand_a << shamt;
      end
      ALU_SRL: begin
        result = operand_a >> shamt;
      end
      // Arithmetic shift keeps the sign
      ALU_SRA: begin
        result = $unsigned($signed(operand_a) >>> shamt);
      end
      ALU_SLT: begin
        result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      end
      ALU_SLTU: begin
        result = {31'b0, operand_a < operand_b};
      end
      ALU_XOR: begin
        result = operand_a ^ operand_b;
      end
      ALU_OR: begin
        result = operand_a | operand_b;
      end
      ALU_AND: begin
        result = operand_a & operand_b;
      end
      // LUI passes the immediate through
      ALU_PASS_B: begin
        result = operand_b;
      end
      default: begin
        result = 32'b0;
      end
    endcase
  end

  // Branch decisions look at this flag
  assign zero = (result == 32'b0);

endmodule

// ==== design/rv_control.sv ====
//--------------------------------------------------------------------------
// Control unit
// Decodes opcode, funct3, funct7 and the ALU zero flag into the control
// word, including the branch decision
//--------------------------------------------------------------------------
module rv_control
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic  rst,
  input  inst_t inst,
  input  logic  alu_zero,
  output ctrl_t ctrl
);

  logic [2:0] funct3;
  logic       alt;
  logic       taken;

  // Integer op from funct3, alt picks SUB or SRA
  function automatic alu_fn_t int_op(input logic [2:0] f3, input logic sub_ok,
                                     input logic f7_alt);
    case (f3)
      F3_ADD:  return (sub_ok && f7_alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return f7_alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign funct3 = inst.r_type.funct3;
  assign alt    = inst.r_type.funct7[5];

  // BEQ/BGE/BGEU take on zero, the others on nonzero
  assign taken = alu_zero ^ funct3[0] ^ funct3[2];

  always_comb begin
    // No-op defaults, also used for unknown opcodes
    ctrl.alu_fn      = ALU_ADD;
    ctrl.a_sel_pc    = 1'b0;
    ctrl.b_sel_imm   = 1'b1;
    ctrl.next_pc_sel = NPC_PLUS4;
    ctrl.wb_sel      = WB_ALU;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_write   = 1'b0;
    case (inst.r_type.opcode)
      OP_LUI: begin
        ctrl.alu_fn    = ALU_PASS_B;
        ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.a_sel_pc  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      // JAL target comes from the PC adder
      OP_JAL: begin
        ctrl.next_pc_sel = NPC_BRANCH;
        ctrl.wb_sel      = WB_PC4;
        ctrl.reg_write   = 1'b1;
      end
      OP_JALR: begin
        ctrl.next_pc_sel = NPC_JALR;
        ctrl.wb_sel      = WB_PC4;
        ctrl.reg_write   = 1'b1;
      end
      // Compare rs1 with rs2
      OP_BRANCH: begin
        ctrl.b_sel_imm   = 1'b0;
        ctrl.alu_fn      = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
        ctrl.next_pc_sel = taken ? NPC_BRANCH : NPC_PLUS4;
      end
      OP_LOAD: begin
        ctrl.wb_sel    = WB_MEM;
        ctrl.reg_write = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
      end
      // ADDI has no subtract form
      OP_IMM: begin
        ctrl.alu_fn    = int_op(funct3, 1'b0, alt);
        ctrl.reg_write = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_fn    = int_op(funct3, 1'b1, alt);
        ctrl.b_sel_imm = 1'b0;
        ctrl.reg_write = 1'b1;
      end
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
    // Nothing is written while in reset
    if (rst) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

endmodule

// ==== design/rv_core.sv ====
//--------------------------------------------------------------------------
// RV32I single-cycle core
// Control unit and data path joined to the fetch and data-memory ports
//--------------------------------------------------------------------------
module rv_core
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
#(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        rst,
  // Instruction fetch, combinational
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  // Data memory, write at the edge
  output dmem_req_t   dmem_req,
  input  logic [31:0] dmem_rdata
);

  inst_t inst;
  ctrl_t ctrl;
  logic  alu_zero;

  // Fetched word viewed through the format union
  assign inst = imem_data;

  // ------------------------------------------------------------------------
  // Decode and control
  // ------------------------------------------------------------------------
  rv_control control_i (
    .rst      (rst),
    .inst     (inst),
    .alu_zero (alu_zero),
    .ctrl     (ctrl)
  );

  // ------------------------------------------------------------------------
  // Data path, PC drives the fetch address
  // ------------------------------------------------------------------------
  rv_datapath #(
    .reset_pc (reset_pc)
  ) datapath_i (
    .clock      (clock),
    .rst        (rst),
    .inst       (inst),
    .ctrl       (ctrl),
    .dmem_rdata (dmem_rdata),
    .pc         (imem_addr),
    .alu_zero   (alu_zero),
    .dmem_req   (dmem_req)
  );

endmodule

// ==== design/rv_ctrl_pkg.sv ====
//--------------------------------------------------------------------------
// Core control types
// Control word from decode to data path and the data-memory request
//--------------------------------------------------------------------------
package rv_ctrl_pkg;
  import rv_isa_pkg::*;

  // Next-PC source
  typedef enum logic [1:0] {
    NPC_PLUS4,
    NPC_BRANCH, // PC plus immediate
    NPC_JALR    // ALU result, bit 0 cleared
  } next_pc_sel_t;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4     // link value for JAL and JALR
  } wb_sel_t;

  // ------------------------------------------------------------------------
  // Control word, one per instruction
  // ------------------------------------------------------------------------
  typedef struct packed {
    alu_fn_t      alu_fn;
    logic         a_sel_pc;   // PC instead of rs1
    logic         b_sel_imm;  // Immediate instead of rs2
    next_pc_sel_t next_pc_sel;
    wb_sel_t      wb_sel;
    logic         reg_write;
    logic         mem_write;
  } ctrl_t;

  // Data-memory request, no handshake
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
    logic        read;
  } dmem_req_t;

endpackage

// ==== design/rv_datapath.sv ====
//--------------------------------------------------------------------------
// Single-cycle data path
// PC register, operand selection, next-PC choice, writeback and the
// data-memory request
//--------------------------------------------------------------------------
module rv_datapath
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
#(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        rst,
  input  inst_t       inst,
  input  ctrl_t       ctrl,
  input  logic [31:0] dmem_rdata,
  output logic [31:0] pc,
  output logic        alu_zero,
  output dmem_req_t   dmem_req
);

  logic [31:0] imm;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] pc_plus4;
  logic [31:0] pc_plus_imm;
  logic [31:0] next_pc;
  logic [31:0] wb_data;

  // ------------------------------------------------------------------------
  // Decode side
  // ------------------------------------------------------------------------
  rv_imm_gen imm_gen_i (
    .inst (inst),
    .imm  (imm)
  );

  // Register indices sit at the same bits in every format
  rv_regfile regfile_i (
    .clock    (clock),
    .rs1_addr (inst.r_type.rs1),
    .rs2_addr (inst.r_type.rs2),
    .rd_addr  (inst.r_type.rd),
    .rd_data  (wb_data),
    .write    (ctrl.reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ------------------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------------------
  assign alu_a = ctrl.a_sel_pc ? pc : rs1_data;
  assign alu_b = ctrl.b_sel_imm ? imm : rs2_data;

  rv_alu alu_i (
    .alu_fn    (ctrl.alu_fn),
    .operand_a (alu_a),
    .operand_b (alu_b),
    .result    (alu_result),
    .zero      (alu_zero)
  );

  // PC adders
  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  // ------------------------------------------------------------------------
  // Next PC and writeback
  // ------------------------------------------------------------------------
  always_comb begin
    case (ctrl.next_pc_sel)
      NPC_BRANCH: next_pc = pc_plus_imm;
      // JALR target is always halfword aligned
      NPC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      default:    next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = dmem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // PC held at reset_pc during reset, written every cycle after
  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // Loads and stores address through the ALU
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.write = ctrl.mem_write;
  assign dmem_req.read  = (ctrl.wb_sel == WB_MEM);

endmodule

// ==== design/rv_imm_gen.sv ====
//--------------------------------------------------------------------------
// Immediate generator
// Sign-extended I, S, B, U or J immediate chosen by the opcode
//--------------------------------------------------------------------------
module rv_imm_gen
  import rv_isa_pkg::*;
(
  input  inst_t       inst,
  output logic [31:0] imm
);

  always_comb begin
    case (inst.r_type.opcode)
      // I format
      OP_JALR, OP_LOAD, OP_IMM: begin
        imm = {{20{inst.i_type.imm_11_0[11]}}, inst.i_type.imm_11_0};
      end
      // S format, split low bits
      OP_STORE: begin
        imm = {{20{inst.s_type.imm_11_5[6]}}, inst.s_type.imm_11_5,
               inst.s_type.imm_4_0};
      end
      // B format, always even
      OP_BRANCH: begin
        imm = {{20{inst.b_type.imm_12}}, inst.b_type.imm_11,
               inst.b_type.imm_10_5, inst.b_type.imm_4_1, 1'b0};
      end
      // Upper 20 bits
      OP_LUI, OP_AUIPC: begin
        imm = {inst.u_type.imm_31_12, 12'b0};
      end
      // J format, also even
      OP_JAL: begin
        imm = {{12{inst.j_type.imm_20}}, inst.j_type.imm_19_12,
               inst.j_type.imm_11, inst.j_type.imm_10_1, 1'b0};
      end
      // Register forms and unknown opcodes
      default: begin
        imm = 32'b0;
      end
    endcase
  end

endmodule

// ==== design/rv_isa_pkg.sv ====
//--------------------------------------------------------------------------
// RV32I instruction set definitions
// Instruction word formats, major opcodes and ALU function codes
//--------------------------------------------------------------------------
package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_fn_t;

  // funct3 of integer operations
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // ------------------------------------------------------------------------
  // Instruction formats, msb first
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
  } r_type_t;
  typedef struct packed {
    logic [11:0] imm_11_0; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0] rd; logic [6:0] opcode;
  } i_type_t;
  typedef struct packed {
    logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
  } s_type_t;
  typedef struct packed {
    logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
  } b_type_t;
  typedef struct packed {
    logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
  } u_type_t;
  typedef struct packed {
    logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
    logic [4:0] rd; logic [6:0] opcode;
  } j_type_t;

  // One word, six views
  typedef union packed {
    r_type_t r_type; i_type_t i_type; s_type_t s_type;
    b_type_t b_type; u_type_t u_type; j_type_t j_type;
  } inst_t;

endpackage

// ==== design/rv_regfile.sv ====
//--------------------------------------------------------------------------
// Register file
// 32 x 32 bits, two combinational reads, one write at the edge, x0 is zero
//--------------------------------------------------------------------------
module rv_regfile (
  input  logic        clock,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  input  logic        write,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  // Write port, x0 never written
  always_ff @(posedge clock) begin
    if (write && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Read ports
  always_comb begin
    if (rs1_addr == 5'd0) begin
      rs1_data = 32'b0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr == 5'd0) begin
      rs2_data = 32'b0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// ==== files.f ====
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/rv_imm_gen.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_datapath.sv
design/rv_control.sv
design/rv_core.sv
testbench/tb_isa_model.sv
testbench/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the RV32I core testbench with Verilator and run it.
# The script exits with the simulation's status.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_core -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_core; then
  echo "Simulation reported a failure"
  exit 1
fi

exit 0

// ==== testbench/tb_core.sv ====
//--------------------------------------------------------------------------
// Testbench for the RV32I single-cycle core
// Memories, clock and reset, and assertion checks against the model
//--------------------------------------------------------------------------
module tb_core
  import rv_ctrl_pkg::*;
  import tb_isa_model::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] start_pc = 32'h0000_0000;

  logic        clock;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_rdata;
  dmem_req_t   dmem_req;
  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  // Position in the expected fetch trace
  int          step = 0;

  rv_core #(
    .reset_pc (start_pc)
  ) dut_i (
    .clock      (clock),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  // ------------------------------------------------------------------------
  // Memories with reads within the cycle and writes at the edge
  // ------------------------------------------------------------------------
  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[11:2]];

  always @(posedge clock) begin
    if (dmem_req.write) begin
      dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
    end
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    abort_run();
  endtask

  // ------------------------------------------------------------------------
  // Clock, program load, reset
  // ------------------------------------------------------------------------
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    rst = 1'b1;
    build_program();
    run_model(start_pc);
    foreach (imem[k]) begin
      imem[k] = prog[k];
    end
    foreach (dmem[k]) begin
      dmem[k] <= 32'b0;
    end
    repeat (16) @(posedge clock);
    #10;
    rst = 1'b0;
  end

  // Budget covers reset, one cycle per instruction and some slack
  initial begin
    #1;
    #((16 + prog_len + 20) * 100);
    $display("Timeout: the program never reached its final self-jump");
    abort_run();
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  reset_store_check: assert property (@(posedge clock) rst |-> !dmem_req.write)
    else report_mismatch("store request while reset is held");

  // Writes only come from SW
  store_opcode_check: assert property (@(posedge clock)
      (!rst && dmem_req.write) |-> (imem_data[6:0] == 7'b0100011))
    else report_mismatch("store request from a non-store instruction");

  // Only LW reads the data memory
  load_read_check: assert property (@(posedge clock)
      !rst |-> (dmem_req.read == (imem_data[6:0] == 7'b0000011)))
    else report_mismatch("data-memory read flag does not match the instruction");

  task automatic check_cycle();
    assert (imem_addr == pc_trace[step])
      else report_mismatch($sformatf("fetch at %h, expected %h", imem_addr, pc_trace[step]));
    if (dmem_req.write) begin
      assert (st_addr.size() > 0)
        else report_mismatch($sformatf("unexpected store to %h", dmem_req.addr));
      assert (dmem_req.addr == st_addr[0] && dmem_req.wdata == st_data[0])
        else report_mismatch($sformatf("store %h to %h, expected %h to %h",
                                       dmem_req.wdata, dmem_req.addr, st_data[0], st_addr[0]));
      void'(st_addr.pop_front());
      void'(st_data.pop_front());
    end
    step++;
    // Self-jump reached
    if (step == pc_trace.size()) begin
      if (st_addr.size() == 0) begin
        $display("NO ERRORS");
        $finish;
      end else begin
        report_mismatch($sformatf("%0d expected stores never seen", st_addr.size()));
      end
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clock) begin
    if (rst) begin
      assert (imem_addr == start_pc)
        else report_mismatch($sformatf("fetch at %h during reset", imem_addr));
    end else begin
      check_cycle();
    end
  end

endmodule

// ==== testbench/tb_isa_model.sv ====
//--------------------------------------------------------------------------
// RV32I program builder and instruction-level reference model
// Predicts the fetch sequence and every store of the test program
//--------------------------------------------------------------------------
package tb_isa_model;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;

  logic [31:0] prog [1024];
  int          prog_len;
  int          n_stores;
  integer      seed;
  // Expected fetch addresses and stores in program order
  logic [31:0] pc_trace [$];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];

  // ------------------------------------------------------------------------
  // Encoders
  // ------------------------------------------------------------------------
  function automatic logic [31:0] i_op(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_op(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  // Offset bit 0 is dropped by the format
  function automatic logic [31:0] b_op(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic void emit(logic [31:0] word);
    prog[10'(prog_len)] = word;
    prog_len++;
  endfunction

  // SW to the next slot of the result area with base x0
  function automatic void store_reg(logic [4:0] rs2);
    logic [11:0] off;
    off = 12'h100 + 12'(4 * n_stores);
    emit({off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE});
    n_stores++;
  endfunction

  // Integer result by funct3 with alt selecting SUB or SRA
  function automatic logic [31:0] int_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Directed sections, random ALU ops and a final self-jump
  // ------------------------------------------------------------------------
  function automatic void build_program();
    logic [4:0]  src_a [4] = '{5'd3, 5'd4, 5'd3, 5'd4};
    logic [4:0]  src_b [4] = '{5'd4, 5'd3, 5'd3, 5'd4};
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic        alt;
    prog_len = 0;
    n_stores = 0;
    seed     = 32'hba70;
    foreach (prog[k]) begin
      prog[k] = 32'b0;
    end
    // A store sits at reset_pc while reset is held
    store_reg(5'd0);
    // LUI x1 and AUIPC x2
    emit({20'h80001, 5'd1, OP_LUI});
    emit({20'h00012, 5'd2, OP_AUIPC});
    store_reg(5'd1);
    store_reg(5'd2);
    // x3 = -5, x4 = 7, branch counter x7 = 0
    emit(i_op(12'hffb, 5'd0, F3_ADD, 5'd3, OP_IMM));
    emit(i_op(12'h007, 5'd0, F3_ADD, 5'd4, OP_IMM));
    emit(i_op(12'h000, 5'd0, F3_ADD, 5'd7, OP_IMM));
    // Every funct3 in register and immediate form
    for (int k = 0; k < 8; k++) begin
      f3 = 3'(k);
      emit(r_op(7'h00, 5'd4, 5'd3, f3, 5'd5));
      store_reg(5'd5);
      imm = (f3 == F3_SLL || f3 == F3_SR) ? 12'd3 : 12'h9a5;
      emit(i_op(imm, 5'd3, f3, 5'd6, OP_IMM));
      store_reg(5'd6);
    end
    // SUB, SRA and SRAI
    emit(r_op(7'h20, 5'd4, 5'd3, F3_ADD, 5'd5));
    store_reg(5'd5);
    emit(r_op(7'h20, 5'd4, 5'd3, F3_SR, 5'd5));
    store_reg(5'd5);
    emit(i_op(12'h403, 5'd3, F3_SR, 5'd6, OP_IMM));
    store_reg(5'd6);
    // Lost write to x0, then SW x3 and LW x8 at 0x40
    emit(i_op(12'h009, 5'd3, F3_ADD, 5'd0, OP_IMM));
    store_reg(5'd0);
    emit({7'd2, 5'd3, 5'd0, 3'b010, 5'd0, OP_STORE});
    emit(i_op(12'h040, 5'd0, 3'b010, 5'd8, OP_LOAD));
    store_reg(5'd8);
    // Six branch types, four operand pairs, a taken branch skips the ADDI
    for (int k = 0; k < 32; k++) begin
      f3 = 3'(k / 4);
      if (f3 != 3'd2 && f3 != 3'd3) begin
        emit(b_op(13'd8, src_b[2'(k)], src_a[2'(k)], f3));
        emit(i_op(12'h001, 5'd7, F3_ADD, 5'd7, OP_IMM));
      end
    end
    store_reg(5'd7);
    // JAL x9 forward by 8
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd9, OP_JAL});
    emit(i_op(12'h001, 5'd7, F3_ADD, 5'd7, OP_IMM));
    store_reg(5'd9);
    // JALR x11 to an odd address that lands 12 past the AUIPC
    emit({20'd0, 5'd10, OP_AUIPC});
    emit(i_op(12'd13, 5'd10, 3'b000, 5'd11, OP_JALR));
    emit(i_op(12'h001, 5'd7, F3_ADD, 5'd7, OP_IMM));
    store_reg(5'd11);
    store_reg(5'd7);
    // Seed x1 to x15 for the random section
    for (int k = 1; k < 16; k++) begin
      emit(i_op(12'($random(seed)), 5'd0, F3_ADD, 5'(k), OP_IMM));
    end
    for (int k = 0; k < 200; k++) begin
      f3  = 3'($random(seed));
      rd  = {1'b0, 4'($random(seed))};
      alt = 1'($random(seed)) && (f3 == F3_ADD || f3 == F3_SR);
      if (1'($random(seed))) begin
        emit(r_op({1'b0, alt, 5'd0}, {1'b0, 4'($random(seed))},
                  {1'b0, 4'($random(seed))}, f3, rd));
      end else if (f3 == F3_SLL || f3 == F3_SR) begin
        imm = {1'b0, alt && (f3 == F3_SR), 5'd0, 5'($random(seed))};
        emit(i_op(imm, {1'b0, 4'($random(seed))}, f3, rd, OP_IMM));
      end else begin
        emit(i_op(12'($random(seed)), {1'b0, 4'($random(seed))}, f3, rd, OP_IMM));
      end
      if (k % 4 == 3) begin
        store_reg(rd);
      end
    end
    // JAL x0, 0 ends the program
    emit({25'd0, OP_JAL});
  endfunction

  // ------------------------------------------------------------------------
  // Reference execution
  // ------------------------------------------------------------------------
  function automatic void run_model(logic [31:0] start_pc);
    logic [31:0] x [32];
    logic [31:0] mem [1024];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] ea;
    logic [31:0] res;
    logic        taken;
    foreach (x[k]) begin
      x[k] = 32'b0;
    end
    foreach (mem[k]) begin
      mem[k] = 32'b0;
    end
    pc = start_pc;
    for (int n = 0; n < 4096; n++) begin
      w = prog[pc[11:2]];
      pc_trace.push_back(pc);
      if (w == {25'd0, OP_JAL}) begin
        break;
      end
      a     = x[w[19:15]];
      b     = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      npc   = pc + 32'd4;
      res   = 32'b0;
      case (w[6:0])
        OP_LUI:   res = {w[31:12], 12'b0};
        OP_AUIPC: res = pc + {w[31:12], 12'b0};
        OP_JAL: begin
          res = npc;
          npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OP_JALR: begin
          res = npc;
          npc = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
          case (w[14:12])
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) begin
            npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        OP_LOAD: begin
          ea  = a + imm_i;
          res = mem[ea[11:2]];
        end
        OP_STORE: begin
          ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
          mem[ea[11:2]] = b;
          st_addr.push_back(ea);
          st_data.push_back(b);
        end
        OP_IMM:  res = int_result(w[14:12], w[30] && (w[14:12] == F3_SR), a, imm_i);
        OP_REG:  res = int_result(w[14:12], w[30], a, b);
        default: res = 32'b0;
      endcase
      // Unknown opcodes and x0 are never written
      if (w[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG} &&
          w[11:7] != 5'd0) begin
        x[w[11:7]] = res;
      end
      pc = npc;
    end
  endfunction

endpackage
